// File: logic/mod_arith_pkg.sv
package mod_arith_pkg;

  localparam int OPERAND_W = 400;
  localparam int CHUNK_W = 6;
  localparam int NUM_CHUNKS = (OPERAND_W + CHUNK_W - 1) / CHUNK_W; // 67, last chunk 4 bits
  localparam int RES_W = 6;    // Moduli up to 63
  localparam int SUM_W = 13;   // 67 * 63 fits

  typedef logic [OPERAND_W-1:0] operand_t;
  typedef logic [CHUNK_W-1:0] chunk_t;
  typedef logic [RES_W-1:0] residue_t;
  typedef logic [SUM_W-1:0] sum_t;
  typedef residue_t [NUM_CHUNKS-1:0] residue_vec_t;

  // 2**n mod m by repeated doubling, so no wide intermediate is needed
  function automatic int pow2_mod(input int n, input int m);
    int r;
    r = 1 % m;
    for (int i = 0; i < n; i++)
    begin
      r = (r * 2) % m;
    end
    return r;
  endfunction

endpackage

// File: logic/mod_io_pkg.sv
package mod_io_pkg;

  localparam int TAG_W = 8;

  typedef logic [TAG_W-1:0] tag_t;

  typedef struct packed {
    tag_t                     tag;
    mod_arith_pkg::operand_t  operand;
  } reduce_req_t;

  typedef struct packed {
    tag_t                     tag;
    mod_arith_pkg::residue_t  residue;  // Always below MODULUS
  } reduce_rsp_t;

endpackage

// File: logic/chunk_weight_lut.sv
`timescale 1ns/1ps

module chunk_weight_lut #(
  parameter int MODULUS = 53,
  parameter int CHUNK_IDX = 0
) (
  input  mod_arith_pkg::chunk_t   chunk,
  output mod_arith_pkg::residue_t residue
);
  import mod_arith_pkg::*;

  localparam int LUT_DEPTH = 2 ** CHUNK_W;
  localparam int WEIGHT = pow2_mod(CHUNK_W * CHUNK_IDX, MODULUS); // 2**(6k) mod m

  typedef residue_t [LUT_DEPTH-1:0] lut_t;

  function automatic lut_t build_lut();
    lut_t lut;
    for (int v = 0; v < LUT_DEPTH; v++)
    begin
      lut[v] = residue_t'((v * WEIGHT) % MODULUS);
    end
    return lut;
  endfunction

  localparam lut_t LUT = build_lut();

  assign residue = LUT[chunk]; // Pure ROM lookup

endmodule

// File: logic/chunk_residue_bank.sv
`timescale 1ns/1ps

module chunk_residue_bank #(
  parameter int MODULUS = 53
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_valid,
  input  mod_io_pkg::tag_t             in_tag,
  input  mod_arith_pkg::operand_t      operand,
  output logic                         out_valid,
  output mod_io_pkg::tag_t             out_tag,
  output mod_arith_pkg::residue_vec_t  residues
);
  import mod_arith_pkg::*;

  localparam int EXT_W = NUM_CHUNKS * CHUNK_W;

  logic [EXT_W-1:0] operand_ext;
  residue_vec_t lut_out;

  assign operand_ext = {{(EXT_W - OPERAND_W){1'b0}}, operand}; // Top chunk zero padded

  for (genvar k = 0; k < NUM_CHUNKS; k++)
  begin : g_chunk
    chunk_weight_lut #(
      .MODULUS   (MODULUS),
      .CHUNK_IDX (k)
    ) u_lut (
      .chunk   (operand_ext[k*CHUNK_W +: CHUNK_W]),
      .residue (lut_out[k])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= in_valid;
  end

  // Payload only moves on a strobe
  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      out_tag  <= in_tag;
      residues <= lut_out;
    end
  end

endmodule

// File: logic/residue_sum_tree.sv
`timescale 1ns/1ps

module residue_sum_tree (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_valid,
  input  mod_io_pkg::tag_t             in_tag,
  input  mod_arith_pkg::residue_vec_t  residues,
  output logic                         out_valid,
  output mod_io_pkg::tag_t             out_tag,
  output mod_arith_pkg::sum_t          sum
);
  import mod_arith_pkg::*;

  localparam int N1 = (NUM_CHUNKS + 2) / 3; // 23
  localparam int N2 = (N1 + 2) / 3;         // 8
  localparam int N3 = (N2 + 2) / 3;         // 3, final adder
  localparam int W1 = RES_W + 2;
  localparam int W2 = W1 + 2;
  localparam int W3 = (W2 + 2 < SUM_W) ? W2 + 2 : SUM_W;

  logic [W1-1:0] lvl1 [N1];
  logic [W2-1:0] lvl2 [N2];
  logic [W3-1:0] lvl3 [N3];
  sum_t total;

  // Missing inputs of a partial group count as zero
  always_comb
  begin
    for (int i = 0; i < N1; i++)
    begin
      lvl1[i] = '0;
      for (int j = 0; j < 3; j++)
        if (3 * i + j < NUM_CHUNKS)
          lvl1[i] = lvl1[i] + W1'(residues[3 * i + j]);
    end
    for (int i = 0; i < N2; i++)
    begin
      lvl2[i] = '0;
      for (int j = 0; j < 3; j++)
        if (3 * i + j < N1)
          lvl2[i] = lvl2[i] + W2'(lvl1[3 * i + j]);
    end
    for (int i = 0; i < N3; i++)
    begin
      lvl3[i] = '0;
      for (int j = 0; j < 3; j++)
        if (3 * i + j < N2)
          lvl3[i] = lvl3[i] + W3'(lvl2[3 * i + j]);
    end
    total = '0;
    for (int j = 0; j < N3; j++)
      total = total + SUM_W'(lvl3[j]);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      out_tag <= in_tag;
      sum     <= total;
    end
  end

endmodule

// File: logic/residue_fold.sv
`timescale 1ns/1ps

module residue_fold #(
  parameter int MODULUS = 53
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  mod_io_pkg::tag_t         in_tag,
  input  mod_arith_pkg::sum_t      sum,
  output logic                     rsp_valid,
  output mod_io_pkg::reduce_rsp_t  rsp
);
  import mod_arith_pkg::*;

  localparam int NUM_PASSES = 3;
  localparam int FOLD_W = RES_W + 3; // 63 + 7 * 62 fits

  typedef logic [FOLD_W-1:0] fold_t;
  typedef residue_t [SUM_W-1:0] weight_vec_t;

  // Weight of each sum bit above the residue field
  function automatic weight_vec_t build_weights();
    weight_vec_t w;
    w = '0;
    for (int j = RES_W; j < SUM_W; j++)
    begin
      w[j] = residue_t'(pow2_mod(j, MODULUS));
    end
    return w;
  endfunction

  localparam weight_vec_t WEIGHTS = build_weights();

  function automatic fold_t fold_once(input sum_t v);
    fold_t acc;
    acc = fold_t'(v[RES_W-1:0]);
    for (int j = RES_W; j < SUM_W; j++)
    begin
      if (v[j])
        acc = acc + fold_t'(WEIGHTS[j]);
    end
    return acc;
  endfunction

  fold_t folded;
  residue_t result;

  always_comb
  begin
    folded = fold_once(sum);
    for (int p = 1; p < NUM_PASSES; p++)
      folded = fold_once(sum_t'(folded));
    if (folded >= fold_t'(MODULUS)) // Below 2*MODULUS here
      result = residue_t'(folded - fold_t'(MODULUS));
    else
      result = residue_t'(folded);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rsp_valid <= 1'b0;
    else
      rsp_valid <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      rsp.tag     <= in_tag;
      rsp.residue <= result;
    end
  end

endmodule

// File: logic/mod_reduce_top.sv
`timescale 1ns/1ps

module mod_reduce_top #(
  parameter int MODULUS = 53
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req_valid,
  input  mod_io_pkg::reduce_req_t  req,
  output logic                     rsp_valid,
  output mod_io_pkg::reduce_rsp_t  rsp
);
  import mod_arith_pkg::*;
  import mod_io_pkg::*;

  logic bank_valid;
  tag_t bank_tag;
  residue_vec_t residues;

  logic tree_valid;
  tag_t tree_tag;
  sum_t sum;

  // Stage 1
  chunk_residue_bank #(
    .MODULUS (MODULUS)
  ) u_bank (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (req_valid),
    .in_tag    (req.tag),
    .operand   (req.operand),
    .out_valid (bank_valid),
    .out_tag   (bank_tag),
    .residues  (residues)
  );

  // Stage 2
  residue_sum_tree u_tree (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (bank_valid),
    .in_tag    (bank_tag),
    .residues  (residues),
    .out_valid (tree_valid),
    .out_tag   (tree_tag),
    .sum       (sum)
  );

  // Stage 3
  residue_fold #(
    .MODULUS (MODULUS)
  ) u_fold (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (tree_valid),
    .in_tag    (tree_tag),
    .sum       (sum),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

endmodule

// File: sim/tb_util.svh
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// Expected response, with the cycle in which it must show up
typedef struct packed {
  logic [31:0] due;
  tag_t        tag;
  residue_t    residue;
} expect_t;

expect_t exp_q[$];
logic [31:0] lcg_state = 32'd3855;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// 13 words of 32 bits cover the 400-bit operand
function automatic operand_t random_operand();
  logic [415:0] wide;
  for (int i = 0; i < 13; i++)
  begin
    wide[i*32 +: 32] = lcg_next();
  end
  return operand_t'(wide);
endfunction

// Reference residue straight from the wide modulus operator
function automatic residue_t ref_mod(input operand_t op);
  operand_t r;
  r = op % operand_t'(TB_MODULUS);
  return residue_t'(r);
endfunction

task automatic abort_run(input string msg);
  $display("%s", msg);
  $display("Test failed");
  $fatal(1);
endtask

task automatic check_value(
  input string       name,
  input logic [63:0] got,
  input logic [63:0] want
);
  if (got !== want)
  begin
    abort_run($sformatf("Error at %0t ns: %s is %0h, expected %0h",
                        $time, name, got, want));
  end
endtask

// Records the expected result for a request driven in this cycle
task automatic push_expect(input tag_t tag, input operand_t op);
  expect_t e;
  e.due     = cycle + 32'd3;
  e.tag     = tag;
  e.residue = ref_mod(op);
  exp_q.push_back(e);
endtask

`endif

// File: sim/mod_reduce_tb.sv
`timescale 1ns/1ps

module mod_reduce_tb;
  import mod_arith_pkg::*;
  import mod_io_pkg::*;

  localparam int TB_MODULUS = 53;
  localparam int CLK_NS = 4;
  localparam int RESET_CYCLES = 8;
  localparam int DRAIN_MAX = 8;
  localparam int NUM_CORNERS = 8;
  localparam int NUM_BURST = 200;
  localparam int NUM_GAPPED = 100;
  localparam int MAX_GAP = 4;
  localparam int NUM_REQS = NUM_CORNERS + OPERAND_W + NUM_BURST + NUM_GAPPED;
  localparam int NUM_IDLE = 10 + NUM_GAPPED * MAX_GAP + 5 * (DRAIN_MAX + 1);
  localparam int WATCHDOG_NS = (NUM_REQS + NUM_IDLE + RESET_CYCLES + 20) * CLK_NS * 2;

  logic clk;
  logic rst;
  logic req_valid;
  reduce_req_t req;
  logic rsp_valid;
  reduce_rsp_t rsp;

  logic [31:0] cycle = '0;   // Rising edges seen so far
  tag_t next_tag;

  `include "tb_util.svh"

  mod_reduce_top #(
    .MODULUS (TB_MODULUS)
  ) DUT (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(CLK_NS / 2) clk = ~clk;
  end

  always @(posedge clk)
    cycle <= cycle + 32'd1;

  initial
  begin
    #(WATCHDOG_NS);
    abort_run("Watchdog expired before all tests completed");
  end

  // Outputs settle after the rising edge, so look at them on the falling one
  always @(negedge clk)
  begin : monitor
    expect_t head;
    if (!rst && rsp_valid)
    begin
      if (exp_q.size() == 0)
        abort_run("Response seen while no request was outstanding");
      head = exp_q.pop_front();
      check_value("rsp_valid cycle", cycle, head.due);
      check_value("rsp.tag", rsp.tag, head.tag);
      check_value("rsp.residue below modulus", rsp.residue < TB_MODULUS, 1'b1);
      check_value("rsp.residue", rsp.residue, head.residue);
    end
  end

  task automatic send_req(input operand_t op);
    @(negedge clk);
    req_valid   = 1'b1;
    req.tag     = next_tag;
    req.operand = op;
    push_expect(next_tag, op);
    next_tag++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(negedge clk);
      req_valid = 1'b0;
    end
  endtask

  // Waits for every outstanding response, bounded by DRAIN_MAX cycles
  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk);
    req_valid = 1'b0;
    while (exp_q.size() != 0 && waited < DRAIN_MAX)
    begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0)
      abort_run("Responses still missing after the pipeline drained");
  endtask

  task automatic test_idle_after_reset();
    repeat (10)
    begin
      @(negedge clk);
      check_value("rsp_valid", rsp_valid, 1'b0);
    end
  endtask

  task automatic test_corners();
    operand_t one;
    one = operand_t'(1);
    send_req('0);
    send_req('1);
    send_req(operand_t'(53));
    send_req(operand_t'(52));
    send_req(one << 399);
    send_req(operand_t'(6'h3f));         // Chunk 0
    send_req(operand_t'(6'h3f) << 6);    // Chunk 1
    send_req(operand_t'(6'h3f) << 396);  // Chunk 66, only 4 bits remain
    drain();
  endtask

  // Walks a single one through every bit, so every table and fold weight is hit
  task automatic test_single_bits();
    for (int pos = 0; pos < OPERAND_W; pos++)
    begin
      send_req(operand_t'(1) << pos);
    end
    drain();
  endtask

  task automatic test_burst();
    next_tag = '0;   // Tags 0 to 199 in order
    for (int i = 0; i < NUM_BURST; i++)
    begin
      send_req(random_operand());
    end
    drain();
  endtask

  task automatic test_gapped();
    int gap;
    for (int i = 0; i < NUM_GAPPED; i++)
    begin
      send_req(random_operand());
      gap = int'(lcg_next() % (MAX_GAP + 1));
      idle_cycles(gap);
    end
    drain();
  endtask

  initial
  begin
    rst         = 1'b1;
    req_valid   = 1'b0;
    req.tag     = '0;
    req.operand = '0;
    next_tag    = '0;

    repeat (RESET_CYCLES)
      @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_idle_after_reset();
    test_corners();
    test_single_bits();
    test_burst();
    test_gapped();

    if (exp_q.size() != 0)
    begin
      abort_run("Expected responses left over at the end of the run");
    end
    else
    begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

// File: tb.f
+incdir+sim
logic/mod_arith_pkg.sv
logic/mod_io_pkg.sv
logic/chunk_weight_lut.sv
logic/chunk_residue_bank.sv
logic/residue_sum_tree.sv
logic/residue_fold.sv
logic/mod_reduce_top.sv
sim/mod_reduce_tb.sv
